// File: Bender.yml
package:
  name: issue_stage

sources:
  - decodePkg.sv
  - instQueue.sv
  - decoder.sv
  - regStatus.sv
  - robAlloc.sv
  - issueStage.sv
  - target: simulation
    files:
      - issueStageTb.sv

// File: decodePkg.sv
package decodePkg;

    //////////////////////////////////////////////////
    // sizes.
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_W = QUEUE_PTR_W + 1;
    localparam int ROB_DEPTH   = 8;
    localparam int ROB_CNT_W   = $clog2(ROB_DEPTH) + 1;
    localparam int NUM_REGS    = 32;

    // major opcodes, inst[6:0].
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    //////////////////////////////////////////////////
    // scalar types.
    typedef logic [31:0]                  instT;
    typedef logic [31:0]                  addrT;
    typedef logic [31:0]                  dataT;
    typedef logic [31:0]                  immT;
    typedef logic [4:0]                   regNameT;
    typedef logic [$clog2(ROB_DEPTH)-1:0] tagT;   // rob index doubles as rename tag.

    typedef enum logic [5:0] {
        NOP, LUI, AUIPC, JAL, JALR,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        LB, LH, LW, LBU, LHU,
        SB, SH, SW,
        ADDI, SLTI, SLTIU, XORI, ORI, ANDI, SLLI, SRLI, SRAI,
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
    } opT;

    //////////////////////////////////////////////////
    // bundles.
    typedef struct packed {
        instT inst;
        addrT pc;
        logic predTaken;
    } fetchT;

    typedef struct packed {
        opT      op;
        regNameT rs1;
        regNameT rs2;
        regNameT rd;
        immT     imm;
        addrT    pc;
        logic    predTaken;
        logic    writesRd;
    } decodedT;

    typedef struct packed {
        logic ready;   // value valid, else wait on tag.
        dataT value;
        tagT  tag;
    } operandT;

    typedef struct packed {
        opT      op;
        immT     imm;
        addrT    pc;
        logic    predTaken;
        regNameT rd;
        tagT     robTag;
        operandT src1;
        operandT src2;
    } dispatchT;

    typedef struct packed {
        regNameT rd;
        tagT     tag;
        dataT    value;
    } commitT;

endpackage

// File: decoder.sv
`timescale 1ns/1ps

module decoder import decodePkg::*; (
    input  fetchT   entry,
    output decodedT decoded
);

    instT       inst;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [3:0] funct;

    assign inst   = entry.inst;
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct  = {inst[30], inst[14:12]};   // bit 30 picks sub/sra.

    always_comb begin
        decoded.rs1       = inst[19:15];
        decoded.rs2       = inst[24:20];
        decoded.rd        = inst[11:7];
        decoded.pc        = entry.pc;
        decoded.predTaken = entry.predTaken;
        decoded.writesRd  = (opcode != OPC_BRANCH) && (opcode != OPC_STORE);

        //////////////////////////////////////////////////
        // immediate formats.
        case (opcode)
            OPC_LUI, OPC_AUIPC: decoded.imm = {inst[31:12], 12'b0};
            OPC_JAL:            decoded.imm = {{12{inst[31]}}, inst[19:12], inst[20],
                                               inst[30:21], 1'b0};
            OPC_BRANCH:         decoded.imm = {{20{inst[31]}}, inst[7], inst[30:25],
                                               inst[11:8], 1'b0};
            OPC_JALR, OPC_OPIMM, OPC_LOAD:
                                decoded.imm = {{21{inst[31]}}, inst[30:20]};
            OPC_STORE:          decoded.imm = {{21{inst[31]}}, inst[30:25], inst[11:7]};
            default:            decoded.imm = '0;
        endcase

        //////////////////////////////////////////////////
        // operation select, undefined encodings fall to nop.
        decoded.op = NOP;
        case (opcode)
            OPC_LUI:   decoded.op = LUI;
            OPC_AUIPC: decoded.op = AUIPC;
            OPC_JAL:   decoded.op = JAL;
            OPC_JALR:  decoded.op = JALR;
            OPC_BRANCH: begin
                case (funct3)
                    3'b000:  decoded.op = BEQ;
                    3'b001:  decoded.op = BNE;
                    3'b100:  decoded.op = BLT;
                    3'b101:  decoded.op = BGE;
                    3'b110:  decoded.op = BLTU;
                    3'b111:  decoded.op = BGEU;
                    default: decoded.op = NOP;
                endcase
            end
            OPC_LOAD: begin
                case (funct3)
                    3'b000:  decoded.op = LB;
                    3'b001:  decoded.op = LH;
                    3'b010:  decoded.op = LW;
                    3'b100:  decoded.op = LBU;
                    3'b101:  decoded.op = LHU;
                    default: decoded.op = NOP;
                endcase
            end
            OPC_STORE: begin
                case (funct3)
                    3'b000:  decoded.op = SB;
                    3'b001:  decoded.op = SH;
                    3'b010:  decoded.op = SW;
                    default: decoded.op = NOP;
                endcase
            end
            OPC_OPIMM: begin
                // bit 30 is immediate here except on shifts.
                case (funct3)
                    3'b000:  decoded.op = ADDI;
                    3'b010:  decoded.op = SLTI;
                    3'b011:  decoded.op = SLTIU;
                    3'b100:  decoded.op = XORI;
                    3'b110:  decoded.op = ORI;
                    3'b111:  decoded.op = ANDI;
                    3'b001:  decoded.op = inst[30] ? NOP : SLLI;
                    default: decoded.op = inst[30] ? SRAI : SRLI;
                endcase
            end
            OPC_OP: begin
                case (funct)
                    4'b0000: decoded.op = ADD;
                    4'b1000: decoded.op = SUB;
                    4'b0001: decoded.op = SLL;
                    4'b0010: decoded.op = SLT;
                    4'b0011: decoded.op = SLTU;
                    4'b0100: decoded.op = XOR;
                    4'b0101: decoded.op = SRL;
                    4'b1101: decoded.op = SRA;
                    4'b0110: decoded.op = OR;
                    4'b0111: decoded.op = AND;
                    default: decoded.op = NOP;
                endcase
            end
            default: decoded.op = NOP;   // csr and system land here too.
        endcase
    end

endmodule

// File: instQueue.sv
`timescale 1ns/1ps

module instQueue import decodePkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  pushEn,
    input  fetchT pushEntry,
    input  logic  popEn,
    output logic  full,
    output logic  headValid,
    output fetchT headEntry
);

    fetchT                  mem [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] wrPtr;
    logic [QUEUE_PTR_W-1:0] rdPtr;
    logic [QUEUE_CNT_W-1:0] count;
    logic                   doPush;
    logic                   doPop;

    assign full      = (count == QUEUE_CNT_W'(QUEUE_DEPTH));
    assign headValid = (count != '0);
    assign headEntry = mem[rdPtr];

    assign doPush = pushEn && !full;   // dropped when full.
    assign doPop  = popEn && headValid;

    // entry storage.
    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= pushEntry;
        end
    end

    //////////////////////////////////////////////////
    // pointers and occupancy.
    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;   // depth is a power of two, wraps.
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // fetch must hold off while fetchReady is low.
    pushWhileFull: assert property (@(posedge clk) disable iff (rst) pushEn |-> !full)
        else $error("instQueue: push dropped while full");

endmodule

// File: issueStage.sv
`timescale 1ns/1ps

module issueStage import decodePkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     rdy,
    input  logic     fetchEn,
    input  fetchT    fetchEntry,
    output logic     fetchReady,
    output logic     dispatchValid,
    output dispatchT dispatchOut,
    input  logic     commitEn,
    input  dataT     commitValue,
    output regNameT  commitRd
);

    logic    queueFull;
    logic    headValid;
    logic    robFull;
    logic    dispatch;
    fetchT   headEntry;
    decodedT decoded;
    tagT     allocTag;
    operandT src1;
    operandT src2;
    commitT  commit;

    assign fetchReady = !queueFull;
    assign dispatch   = headValid && rdy && !robFull;
    assign commitRd   = commit.rd;

    instQueue queue0 (
        .clk(clk), .rst(rst), .pushEn(fetchEn), .pushEntry(fetchEntry), .popEn(dispatch),
        .full(queueFull), .headValid(headValid), .headEntry(headEntry)
    );

    decoder decoder0 (.entry(headEntry), .decoded(decoded));

    robAlloc rob0 (
        .clk(clk), .rst(rst), .allocEn(dispatch), .allocRd(decoded.rd), .allocTag(allocTag),
        .full(robFull), .commitEn(commitEn), .commitValue(commitValue), .commit(commit)
    );

    regStatus regStatus0 (
        .clk(clk), .rst(rst), .rs1(decoded.rs1), .rs2(decoded.rs2), .src1(src1), .src2(src2),
        .renameEn(dispatch && decoded.writesRd), .renameRd(decoded.rd), .renameTag(allocTag),
        .commitEn(commitEn), .commit(commit)
    );

    //////////////////////////////////////////////////
    // dispatch register.
    always_ff @(posedge clk) begin
        if (rst) begin
            dispatchValid <= 1'b0;
        end else begin
            dispatchValid <= dispatch;   // one cycle per dispatch.
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch) begin
            dispatchOut <= '{op: decoded.op, imm: decoded.imm, pc: decoded.pc,
                             predTaken: decoded.predTaken, rd: decoded.rd,
                             robTag: allocTag, src1: src1, src2: src2};
        end
    end

endmodule

// File: issueStageTb.sv
`timescale 1ns/1ps

module issueStageTb import decodePkg::*; ();

    localparam int NUM_ROWS  = 24;
    localparam int NUM_BURST = 12;
    localparam int HALF      = 4;

    typedef struct packed {
        instT inst;
        addrT pc;
        logic pred;
        opT   expOp;
        immT  expImm;
        logic doCommit;   // retire the oldest entry after this row.
    } rowT;

    typedef struct packed {
        regNameT rd;
        tagT     tag;
    } robEntryT;

    logic     clk;
    logic     rst;
    logic     rdy;
    logic     fetchEn;
    fetchT    fetchEntry;
    logic     fetchReady;
    logic     dispatchValid;
    dispatchT dispatchOut;
    logic     commitEn;
    dataT     commitValue;
    regNameT  commitRd;

    rowT                 rowTable [NUM_ROWS];
    int                  numRows;
    int                  errors;
    int                  checks;
    logic [31:0]         lfsrState;
    dispatchT            seen [$];
    robEntryT            modelRob [$];
    logic [NUM_REGS-1:0] busyM;
    tagT                 tagM [NUM_REGS];
    dataT                valueM [NUM_REGS];
    tagT                 nextTag;

    issueStage dut0 (
        .clk(clk), .rst(rst), .rdy(rdy), .fetchEn(fetchEn), .fetchEntry(fetchEntry),
        .fetchReady(fetchReady), .dispatchValid(dispatchValid), .dispatchOut(dispatchOut),
        .commitEn(commitEn), .commitValue(commitValue), .commitRd(commitRd)
    );

    initial begin
        clk = 1'b0;
        forever #HALF clk = ~clk;
    end

    // dispatch monitor, sampled mid-cycle.
    always @(negedge clk) begin
        if (!rst && dispatchValid) begin
            seen.push_back(dispatchOut);
        end
    end

    initial begin
        repeat (NUM_ROWS * 20) @(posedge clk);
        $display("watchdog expired after %0d cycles, run did not complete", NUM_ROWS * 20);
        $display("STATUS: FAIL");
        $finish;
    end

    //////////////////////////////////////////////////
    // compare tasks.
    task automatic checkOp(string name, opT got, opT exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: expected 0x%h, got 0x%h", name, exp, got);
        end
    endtask

    task automatic checkData(string name, dataT got, dataT exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: expected 0x%h, got 0x%h", name, exp, got);
        end
    endtask

    task automatic checkTag(string name, tagT got, tagT exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: expected 0x%h, got 0x%h", name, exp, got);
        end
    endtask

    task automatic checkName(string name, regNameT got, regNameT exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: expected 0x%h, got 0x%h", name, exp, got);
        end
    endtask

    task automatic checkFlag(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: expected 0x%h, got 0x%h", name, exp, got);
        end
    endtask

    task automatic checkOperand(string name, operandT got, operandT exp);
        checkFlag({name, ".ready"}, got.ready, exp.ready);
        if (exp.ready) begin
            checkData({name, ".value"}, got.value, exp.value);
        end else begin
            checkTag({name, ".tag"}, got.tag, exp.tag);
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus helpers.
    function automatic dataT randWord();
        dataT w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            // taps 32, 22, 2, 1.
            lfsrState = {lfsrState[30:0],
                         lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0]};
            w = {w[30:0], lfsrState[0]};
        end
        return w;
    endfunction

    function automatic instT encR(logic [6:0] f7, regNameT rs2, regNameT rs1,
                                  logic [2:0] f3, regNameT rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic instT encI(logic [11:0] imm, regNameT rs1, logic [2:0] f3,
                                  regNameT rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic instT encS(logic [11:0] imm, regNameT rs2, regNameT rs1, logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic instT encB(logic [12:0] imm, regNameT rs2, regNameT rs1, logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic instT encU(logic [19:0] imm, regNameT rd, logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic instT encJ(logic [20:0] imm, regNameT rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    task automatic addRow(instT inst, opT op, immT imm, logic doCommit);
        rowTable[numRows] = '{inst: inst, pc: addrT'(32'h1000 + 4 * numRows),
                              pred: (numRows % 3 == 0), expOp: op, expImm: imm,
                              doCommit: doCommit};
        numRows++;
    endtask

    task automatic buildTable();
        addRow(encU(20'hABCDE, 5'd1, OPC_LUI), LUI, 32'hABCDE000, 1'b0);
        addRow(encU(20'h80001, 5'd2, OPC_AUIPC), AUIPC, 32'h80001000, 1'b1);
        addRow(encR(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), ADD, 32'h0, 1'b1);
        addRow(encR(7'h20, 5'd2, 5'd3, 3'b000, 5'd4), SUB, 32'h0, 1'b0);
        addRow(encI(12'hFFB, 5'd4, 3'b000, 5'd5, OPC_OPIMM), ADDI, 32'hFFFFFFFB, 1'b1);
        addRow(encI(12'h7FF, 5'd0, 3'b000, 5'd5, OPC_OPIMM), ADDI, 32'h000007FF, 1'b1);
        addRow(encR(7'h00, 5'd4, 5'd5, 3'b100, 5'd6), XOR, 32'h0, 1'b1);
        addRow(encR(7'h00, 5'd0, 5'd5, 3'b110, 5'd7), OR, 32'h0, 1'b0);   // younger x5 tag.
        addRow(encB(13'h1FF0, 5'd6, 5'd5, 3'b000), BEQ, 32'hFFFFFFF0, 1'b0);
        addRow(encR(7'h00, 5'd0, 5'd17, 3'b000, 5'd8), ADD, 32'h0, 1'b1);
        addRow(encS(12'h029, 5'd6, 5'd1, 3'b010), SW, 32'h00000029, 1'b1);
        addRow(encR(7'h00, 5'd6, 5'd9, 3'b010, 5'd9), SLT, 32'h0, 1'b1);
        addRow(encI(12'h800, 5'd5, 3'b010, 5'd10, OPC_LOAD), LW, 32'hFFFFF800, 1'b1);
        addRow(encJ(21'h012346, 5'd1), JAL, 32'h00012346, 1'b1);
        addRow(encJ(21'h1FFFFC, 5'd0), JAL, 32'hFFFFFFFC, 1'b0);
        addRow(encI(12'h008, 5'd1, 3'b000, 5'd11, OPC_JALR), JALR, 32'h00000008, 1'b1);
        addRow(encI(12'h403, 5'd10, 3'b101, 5'd12, OPC_OPIMM), SRAI, 32'h00000403, 1'b1);
        addRow(encI(12'h401, 5'd12, 3'b001, 5'd13, OPC_OPIMM), NOP, 32'h00000401, 1'b1);
        addRow(encB(13'h0008, 5'd2, 5'd3, 3'b010), NOP, 32'h00000008, 1'b1);
        addRow(encI(12'h300, 5'd8, 3'b111, 5'd14, 7'b1110011), NOP, 32'h0, 1'b1);   // csr.
        addRow(encB(13'h1000, 5'd1, 5'd13, 3'b101), BGE, 32'hFFFFF000, 1'b1);
        addRow(encS(12'hFFF, 5'd11, 5'd13, 3'b001), SH, 32'hFFFFFFFF, 1'b1);
        addRow(encI(12'h123, 5'd12, 3'b100, 5'd15, OPC_LOAD), LBU, 32'h00000123, 1'b1);
        addRow(encR(7'h00, 5'd14, 5'd13, 3'b111, 5'd16), AND, 32'h0, 1'b1);
    endtask

    //////////////////////////////////////////////////
    // reference model of the rename table.
    function automatic operandT expectOperand(regNameT rs);
        operandT o;
        o = '0;
        if (rs == '0) begin
            o.ready = 1'b1;
        end else if (busyM[rs]) begin
            o.tag = tagM[rs];
        end else begin
            o.ready = 1'b1;
            o.value = valueM[rs];
        end
        return o;
    endfunction

    function automatic logic writesDest(instT inst);
        return (inst[6:0] != OPC_BRANCH) && (inst[6:0] != OPC_STORE);
    endfunction

    task automatic pushOne(fetchT e);
        @(negedge clk);
        while (!fetchReady) begin
            @(negedge clk);
        end
        @(posedge clk);
        fetchEn    <= 1'b1;
        fetchEntry <= e;
        @(posedge clk);
        fetchEn <= 1'b0;
    endtask

    task automatic commitOne();
        robEntryT e;
        dataT     v;
        if (modelRob.size() == 0) begin
            errors++;
            $display("commit requested with no instruction in flight");
        end else begin
            e = modelRob.pop_front();
            v = randWord();
            @(posedge clk);
            commitEn    <= 1'b1;
            commitValue <= v;
            @(negedge clk);
            checkName("commitRd", commitRd, e.rd);
            @(posedge clk);
            commitEn <= 1'b0;
            if (busyM[e.rd] && (tagM[e.rd] == e.tag)) begin
                valueM[e.rd] = v;
                busyM[e.rd]  = 1'b0;
            end
        end
    endtask

    task automatic waitDispatch(output dispatchT d, output logic got);
        int n;
        n   = 0;
        got = 1'b0;
        while ((seen.size() == 0) && (n < 20)) begin
            @(posedge clk);
            n++;
        end
        if (seen.size() != 0) begin
            d   = seen.pop_front();
            got = 1'b1;
        end
    endtask

    task automatic runRow(int r);
        rowT      row;
        dispatchT d;
        logic     got;
        operandT  exp1;
        operandT  exp2;
        regNameT  rd;
        robEntryT re;
        opT       op;
        int       errBefore;
        row       = rowTable[r];
        op        = row.expOp;
        rd        = row.inst[11:7];
        errBefore = errors;
        pushOne('{inst: row.inst, pc: row.pc, predTaken: row.pred});
        waitDispatch(d, got);
        if (!got) begin
            errors++;
            $display("row %0d: no dispatch within 20 cycles", r);
        end else begin
            exp1 = expectOperand(row.inst[19:15]);
            exp2 = expectOperand(row.inst[24:20]);   // looked up even when unused.
            checkOp("op", d.op, row.expOp);
            checkData("imm", d.imm, row.expImm);
            checkData("pc", d.pc, row.pc);
            checkFlag("predTaken", d.predTaken, row.pred);
            checkName("rd", d.rd, rd);
            checkTag("robTag", d.robTag, nextTag);
            checkOperand("src1", d.src1, exp1);
            checkOperand("src2", d.src2, exp2);
            if (writesDest(row.inst) && (rd != '0)) begin
                busyM[rd] = 1'b1;
                tagM[rd]  = nextTag;
            end
            re.rd  = rd;
            re.tag = nextTag;
            modelRob.push_back(re);
            nextTag++;
        end
        if (row.doCommit) begin
            commitOne();
        end
        if (errors == errBefore) begin
            $display("row %0d %s: ok", r, op.name());
        end else begin
            $display("row %0d %s: %0d errors", r, op.name(), errors - errBefore);
        end
    endtask

    function automatic fetchT burstEntry(int i);
        fetchT e;
        e.inst      = encI(12'(i + 1), 5'd0, 3'b000, regNameT'(18 + i), OPC_OPIMM);
        e.pc        = addrT'(32'h2000 + 4 * i);
        e.predTaken = 1'b0;
        return e;
    endfunction

    // queue and rob fill with commits held back, then drain.
    task automatic runBackPressure();
        dispatchT d;
        robEntryT re;
        tagT      startTag;
        int       errBefore;
        int       n;
        errBefore = errors;
        startTag  = nextTag;
        if (seen.size() != 0) begin
            errors++;
            $display("backpressure: %0d unexpected dispatches left over", seen.size());
        end
        @(posedge clk);
        rdy <= 1'b0;
        for (int i = 0; i < NUM_BURST; i++) begin
            if (i == QUEUE_DEPTH) begin
                repeat (4) @(negedge clk);
                checkFlag("fetchReady", fetchReady, 1'b0);
                @(posedge clk);
                if (seen.size() != 0) begin
                    errors++;
                    $display("backpressure: dispatch occurred while rdy was low");
                end
                rdy <= 1'b1;
            end
            re.rd  = regNameT'(18 + i);
            re.tag = nextTag;
            modelRob.push_back(re);
            nextTag++;
            pushOne(burstEntry(i));
        end
        repeat (12) @(negedge clk);
        checkFlag("fetchReady", fetchReady, 1'b0);
        @(posedge clk);
        if (seen.size() != ROB_DEPTH) begin
            errors++;
            $display("backpressure: %0d dispatches with commits held, wanted %0d",
                     seen.size(), ROB_DEPTH);
        end
        while (modelRob.size() != 0) begin
            commitOne();
        end
        n = 0;
        while ((seen.size() < NUM_BURST) && (n < 20)) begin
            @(posedge clk);
            n++;
        end
        repeat (4) @(posedge clk);
        if (seen.size() != NUM_BURST) begin
            errors++;
            $display("backpressure: %0d dispatches seen, wanted %0d", seen.size(), NUM_BURST);
        end else begin
            for (int i = 0; i < NUM_BURST; i++) begin
                d = seen.pop_front();
                checkOp("op", d.op, ADDI);
                checkData("imm", d.imm, dataT'(i + 1));
                checkData("pc", d.pc, addrT'(32'h2000 + 4 * i));
                checkName("rd", d.rd, regNameT'(18 + i));
                checkTag("robTag", d.robTag, tagT'(startTag + i));
            end
        end
        if (errors == errBefore) begin
            $display("backpressure: ok");
        end else begin
            $display("backpressure: %0d errors", errors - errBefore);
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence.
    initial begin
        rst         = 1'b1;
        rdy         = 1'b1;
        fetchEn     = 1'b0;
        fetchEntry  = '0;
        commitEn    = 1'b0;
        commitValue = '0;
        errors      = 0;
        checks      = 0;
        numRows     = 0;
        nextTag     = '0;
        lfsrState   = 32'h6d19_c28b;
        busyM       = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            valueM[i] = '0;
            tagM[i]   = '0;
        end
        buildTable();
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkFlag("dispatchValid", dispatchValid, 1'b0);
        checkFlag("fetchReady", fetchReady, 1'b1);
        $display("reset state: %s", (errors == 0) ? "ok" : "wrong");
        for (int r = 0; r < numRows; r++) begin
            runRow(r);
        end
        while (modelRob.size() != 0) begin
            commitOne();
        end
        runBackPressure();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: regStatus.sv
`timescale 1ns/1ps

module regStatus import decodePkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  regNameT rs1,
    input  regNameT rs2,
    output operandT src1,
    output operandT src2,
    input  logic    renameEn,
    input  regNameT renameRd,
    input  tagT     renameTag,
    input  logic    commitEn,
    input  commitT  commit
);

    dataT                value [NUM_REGS];
    tagT                 tag   [NUM_REGS];
    logic [NUM_REGS-1:0] busy;
    logic                doRename;
    logic                commitHit;

    assign doRename  = renameEn && (renameRd != '0);   // x0 never renamed.
    assign commitHit = commitEn && busy[commit.rd] && (tag[commit.rd] == commit.tag);

    //////////////////////////////////////////////////
    // operand lookup.
    function automatic operandT lookup(regNameT rs);
        operandT res;
        res = '0;
        if (rs == '0) begin
            res.ready = 1'b1;
        end else if (busy[rs] && commitEn && (tag[rs] == commit.tag)) begin
            res.ready = 1'b1;
            res.value = commit.value;   // producer retires this cycle.
        end else if (busy[rs]) begin
            res.tag = tag[rs];
        end else begin
            res.ready = 1'b1;
            res.value = value[rs];
        end
        return res;
    endfunction

    always_comb begin
        src1 = lookup(rs1);
        src2 = lookup(rs2);
    end

    //////////////////////////////////////////////////
    // busy and value update.
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
            for (int i = 0; i < NUM_REGS; i++) begin
                value[i] <= '0;
            end
        end else begin
            if (commitHit) begin
                value[commit.rd] <= commit.value;
                busy[commit.rd]  <= 1'b0;
            end
            if (doRename) begin
                busy[renameRd] <= 1'b1;   // younger rename beats the commit.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (doRename) begin
            tag[renameRd] <= renameTag;
        end
    end

endmodule

// File: robAlloc.sv
`timescale 1ns/1ps

module robAlloc import decodePkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    allocEn,
    input  regNameT allocRd,
    output tagT     allocTag,
    output logic    full,
    input  logic    commitEn,
    input  dataT    commitValue,
    output commitT  commit
);

    regNameT              rdMem [ROB_DEPTH];
    tagT                  head;
    tagT                  tail;
    logic [ROB_CNT_W-1:0] count;
    logic                 empty;
    logic                 doAlloc;
    logic                 doCommit;

    assign full     = (count == ROB_CNT_W'(ROB_DEPTH));
    assign empty    = (count == '0);
    assign doAlloc  = allocEn && !full;
    assign doCommit = commitEn && !empty;
    assign allocTag = tail;   // next free slot.

    assign commit = '{rd: rdMem[head], tag: head, value: commitValue};

    always_ff @(posedge clk) begin
        if (doAlloc) begin
            rdMem[tail] <= allocRd;
        end
    end

    //////////////////////////////////////////////////
    // in-order allocate and retire.
    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (doAlloc) begin
                tail <= tail + 1'b1;
            end
            if (doCommit) begin
                head <= head + 1'b1;
            end
            case ({doAlloc, doCommit})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // retirement must only be signalled for an instruction in flight.
    commitWhileEmpty: assert property (@(posedge clk) disable iff (rst) commitEn |-> !empty)
        else $error("robAlloc: commit with nothing in flight");

endmodule

// File: vlog.f
decodePkg.sv
instQueue.sv
decoder.sv
regStatus.sv
robAlloc.sv
issueStage.sv
issueStageTb.sv
